// File: design/cpuPkg.sv
package cpuPkg;

	// Machine sizes
	localparam int dataWidth    = 16;
	localparam int regCount     = 16;
	localparam int regIdxWidth  = 4;
	localparam int immWidth     = 8;
	localparam int memDepth     = 256;
	localparam int memAddrWidth = 8;

	// Instruction bits 15..12
	typedef enum logic [3:0] {
		ADD = 4'h0,
		SUB = 4'h1,
		AND = 4'h2,
		OR  = 4'h3,
		XOR = 4'h4,
		SHL = 4'h5,
		SHR = 4'h6,
		MOV = 4'h7,
		LDI = 4'h8,
		LD  = 4'h9,
		ST  = 4'ha,
		JMP = 4'hb,
		JR  = 4'hc,
		JZ  = 4'hd,
		JC  = 4'he,
		HLT = 4'hf
	} opcodeT;

	// Register writeback source
	typedef enum logic [1:0] {
		wbAlu,
		wbImm,
		wbMem
	} wbSelT;

	// Data address source when the core owns the bus
	typedef enum logic [1:0] {
		addrDst,
		addrSrc,
		addrImm
	} memAddrSelT;

	typedef enum logic [1:0] {
		pcInc,
		pcImm,
		pcSrc
	} nextPcSelT;

	// Decoded control bundle, valid during the execute cycle
	typedef struct packed {
		opcodeT                 op;
		logic [regIdxWidth-1:0] regDst;
		logic [regIdxWidth-1:0] regSrc;
		logic                   regWe;
		logic                   flagWe;
		logic                   memWe;
		logic                   memBusSel;
		memAddrSelT             memAddrSel;
		wbSelT                  wbSel;
		nextPcSelT              nextPcSel;
		logic                   halt;
		logic [dataWidth-1:0]   imm;
	} ctrlT;

	// Host side of the memory port
	typedef struct packed {
		logic                    we;
		logic [memAddrWidth-1:0] addr;
		logic [dataWidth-1:0]    wrData;
	} hostReqT;

endpackage

// File: design/registerFile.sv
`timescale 1ns/1ps

module registerFile (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           we,
	input  logic [cpuPkg::regIdxWidth-1:0] regDst,
	input  logic [cpuPkg::dataWidth-1:0]   regDstDataIn,
	output logic [cpuPkg::dataWidth-1:0]   regDstDataOut,
	input  logic [cpuPkg::regIdxWidth-1:0] regSrc,
	output logic [cpuPkg::dataWidth-1:0]   regSrcDataOut
);
	import cpuPkg::*;

	logic [dataWidth-1:0] regs [regCount];

	// Single write port, at the destination index
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[regDst] <= regDstDataIn;
		end
	end

	// Asynchronous reads so execute sees current values
	assign regDstDataOut = regs[regDst];
	assign regSrcDataOut = regs[regSrc];

endmodule

// File: design/alu.sv
`timescale 1ns/1ps

module alu (
	input  logic                         clk,
	input  logic                         rst,
	input  cpuPkg::ctrlT                 ctrl,
	input  logic [cpuPkg::dataWidth-1:0] in1,
	input  logic [cpuPkg::dataWidth-1:0] in2,
	output logic [cpuPkg::dataWidth-1:0] out,
	output logic                         cFlag,
	output logic                         zFlag
);
	import cpuPkg::*;

	logic [dataWidth:0] wide;
	logic               carryNext;

	always_comb begin
		wide = '0;
		case (ctrl.op)
			ADD: wide = {1'b0, in1} + {1'b0, in2};
			// Top bit is the borrow
			SUB: wide = {1'b0, in1} - {1'b0, in2};
			AND: wide = {1'b0, in1 & in2};
			OR:  wide = {1'b0, in1 | in2};
			XOR: wide = {1'b0, in1 ^ in2};
			SHL: wide = {in1, 1'b0};
			MOV: wide = {1'b0, in2};
			default: wide = '0;
		endcase
	end

	// SHR shifts its bit out of the bottom, the rest out of bit 16
	always_comb begin
		if (ctrl.op == SHR) begin
			out       = in1 >> 1;
			carryNext = in1[0];
		end else begin
			out       = wide[dataWidth-1:0];
			carryNext = wide[dataWidth];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cFlag <= 1'b0;
			zFlag <= 1'b0;
		end else if (ctrl.flagWe) begin
			cFlag <= carryNext;
			zFlag <= (out == '0);
		end
	end

	// Only the eight ALU opcodes may touch the flags
	flagWeAluOnly: assert property (@(posedge clk) disable iff (rst)
		ctrl.flagWe |-> ctrl.op inside {ADD, SUB, AND, OR, XOR, SHL, SHR, MOV});

endmodule

// File: design/decoder.sv
`timescale 1ns/1ps

module decoder (
	input  logic [cpuPkg::dataWidth-1:0] instruction,
	input  logic                         ce,
	input  logic                         cFlag,
	input  logic                         zFlag,
	output cpuPkg::ctrlT                 ctrl
);
	import cpuPkg::*;

	opcodeT op;

	assign op = opcodeT'(instruction[dataWidth-1 -: 4]);

	always_comb begin
		// Field split, independent of the opcode
		ctrl.op     = op;
		ctrl.regDst = instruction[11:8];
		ctrl.regSrc = instruction[7:4];
		ctrl.imm    = {{(dataWidth-immWidth){1'b0}}, instruction[immWidth-1:0]};

		// Quiet defaults, no strobes
		ctrl.regWe      = 1'b0;
		ctrl.flagWe     = 1'b0;
		ctrl.memWe      = 1'b0;
		ctrl.memBusSel  = 1'b0;
		ctrl.halt       = 1'b0;
		ctrl.memAddrSel = addrDst;
		ctrl.wbSel      = wbAlu;
		ctrl.nextPcSel  = pcInc;

		if (ce) begin
			case (op)
				ADD, SUB, AND, OR, XOR, SHL, SHR, MOV: begin
					ctrl.regWe  = 1'b1;
					ctrl.flagWe = 1'b1;
					ctrl.wbSel  = wbAlu;
				end
				LDI: begin
					ctrl.regWe = 1'b1;
					ctrl.wbSel = wbImm;
				end
				// rDst <= mem[rSrc]
				LD: begin
					ctrl.regWe      = 1'b1;
					ctrl.wbSel      = wbMem;
					ctrl.memBusSel  = 1'b1;
					ctrl.memAddrSel = addrSrc;
				end
				// mem[rDst] <= rSrc
				ST: begin
					ctrl.memWe      = 1'b1;
					ctrl.memBusSel  = 1'b1;
					ctrl.memAddrSel = addrDst;
				end
				JMP: begin
					ctrl.nextPcSel = pcImm;
				end
				JR: begin
					ctrl.nextPcSel = pcSrc;
				end
				JZ: begin
					ctrl.nextPcSel = zFlag ? pcImm : pcInc;
				end
				JC: begin
					ctrl.nextPcSel = cFlag ? pcImm : pcInc;
				end
				HLT: begin
					ctrl.halt = 1'b1;
				end
				default: begin
					ctrl.halt = 1'b0;
				end
			endcase
		end
	end

endmodule

// File: design/processor.sv
`timescale 1ns/1ps

module processor (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         run,
	output logic [cpuPkg::dataWidth-1:0] addrBus,
	input  logic [cpuPkg::dataWidth-1:0] dataIn,
	output logic [cpuPkg::dataWidth-1:0] dataOut,
	output logic                         memWe,
	output logic                         halted
);
	import cpuPkg::*;

	typedef enum logic {
		stFetch,
		stExecute
	} stateT;

	stateT                state;
	logic [dataWidth-1:0] pc;
	logic [dataWidth-1:0] nextPc;
	logic [dataWidth-1:0] instruction;
	logic                 decoderCe;
	logic                 decodeEn;
	logic                 stepEn;

	ctrlT                 ctrl;
	logic [dataWidth-1:0] regDstData;
	logic [dataWidth-1:0] regSrcData;
	logic [dataWidth-1:0] regDstDataIn;
	logic [dataWidth-1:0] aluOut;
	logic [dataWidth-1:0] memAddr;
	logic                 cFlag;
	logic                 zFlag;

	// Frozen while run is low; only reset leaves the halted state
	assign stepEn   = run && !halted;
	assign decodeEn = decoderCe && run;

	registerFile regFile (
		.clk          (clk),
		.rst          (rst),
		.we           (ctrl.regWe),
		.regDst       (ctrl.regDst),
		.regDstDataIn (regDstDataIn),
		.regDstDataOut(regDstData),
		.regSrc       (ctrl.regSrc),
		.regSrcDataOut(regSrcData)
	);

	alu aluCore (
		.clk  (clk),
		.rst  (rst),
		.ctrl (ctrl),
		.in1  (regDstData),
		.in2  (regSrcData),
		.out  (aluOut),
		.cFlag(cFlag),
		.zFlag(zFlag)
	);

	decoder decode (
		.instruction(instruction),
		.ce         (decodeEn),
		.cFlag      (cFlag),
		.zFlag      (zFlag),
		.ctrl       (ctrl)
	);

	always_comb begin
		case (ctrl.nextPcSel)
			pcImm:   nextPc = ctrl.imm;
			pcSrc:   nextPc = regSrcData;
			default: nextPc = pc + 1'b1;
		endcase
	end

	always_comb begin
		case (ctrl.memAddrSel)
			addrSrc: memAddr = regSrcData;
			addrImm: memAddr = ctrl.imm;
			default: memAddr = regDstData;
		endcase
	end

	always_comb begin
		case (ctrl.wbSel)
			wbImm:   regDstDataIn = ctrl.imm;
			wbMem:   regDstDataIn = dataIn;
			default: regDstDataIn = aluOut;
		endcase
	end

	// PC on the bus during fetch, data address for LD/ST
	assign addrBus = ctrl.memBusSel ? memAddr : pc;
	assign dataOut = regSrcData;
	assign memWe   = ctrl.memWe;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state     <= stFetch;
			pc        <= '0;
			halted    <= 1'b0;
			decoderCe <= 1'b0;
		end else if (stepEn) begin
			case (state)
				stFetch: begin
					decoderCe <= 1'b1;
					state     <= stExecute;
				end
				default: begin
					decoderCe <= 1'b0;
					state     <= stFetch;
					if (ctrl.halt) begin
						halted <= 1'b1;
					end else begin
						pc <= nextPc;
					end
				end
			endcase
		end
	end

	// Instruction latch
	always_ff @(posedge clk) begin
		if (stepEn && state == stFetch) begin
			instruction <= dataIn;
		end
	end

	memWeInExecute: assert property (@(posedge clk) disable iff (rst)
		memWe |-> state == stExecute);

	pcHeldWhileHalted: assert property (@(posedge clk) disable iff (rst)
		halted |=> $stable(pc));

endmodule

// File: design/processorTop.sv
`timescale 1ns/1ps

module processorTop (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         run,
	input  cpuPkg::hostReqT              hostReq,
	output logic [cpuPkg::dataWidth-1:0] hostRdData,
	output logic                         halted
);
	import cpuPkg::*;

	logic [dataWidth-1:0]    memory [memDepth];
	logic [dataWidth-1:0]    addrBus;
	logic [dataWidth-1:0]    coreDataOut;
	logic [dataWidth-1:0]    rdData;
	logic [memAddrWidth-1:0] rdAddr;
	logic                    coreWe;

	// Run level decides who owns the memory
	assign rdAddr     = run ? addrBus[memAddrWidth-1:0] : hostReq.addr;
	assign rdData     = memory[rdAddr];
	assign hostRdData = rdData;

	always_ff @(posedge clk) begin
		if (run) begin
			if (coreWe) begin
				memory[addrBus[memAddrWidth-1:0]] <= coreDataOut;
			end
		end else if (hostReq.we) begin
			memory[hostReq.addr] <= hostReq.wrData;
		end
	end

	processor cpu (
		.clk    (clk),
		.rst    (rst),
		.run    (run),
		.addrBus(addrBus),
		.dataIn (rdData),
		.dataOut(coreDataOut),
		.memWe  (coreWe),
		.halted (halted)
	);

	// Host writes are dropped while the core runs
	noHostWriteWhileRun: assert property (@(posedge clk) disable iff (rst)
		run |-> !hostReq.we);

endmodule

// File: tests/clockGen.sv
`timescale 1ns/1ps

module clockGen (
	input  logic restart,
	output logic clk,
	output logic rst
);
	initial clk = 1'b0;
	initial rst = 1'b1;

	// 40 ns period
	always #20 clk = ~clk;

	// Reset held for 10 cycles at start and after every restart pulse
	always begin
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(posedge restart);
		rst <= 1'b1;
	end

endmodule

// File: tests/tbTop.sv
`timescale 1ns/1ps

module tbTop;
	import cpuPkg::*;

	localparam int tableLen    = 19;
	localparam int progLen     = 27;
	// Reset, program and data load, longest run, read-back
	localparam int entryCycles = 14 + (progLen + 8) + 2 * 25 + 12;
	localparam int echoCycles  = 8 * 3 + 12;
	localparam int timeoutCycles = tableLen * entryCycles + echoCycles + 200;

	typedef struct packed {
		opcodeT     op;
		logic [7:0] a;
		logic [7:0] b;
		logic       cTaken;
		logic       zTaken;
	} entryT;

	typedef struct packed {
		logic        c;
		logic        z;
		logic [15:0] r;
	} aluRefT;

	logic        clk;
	logic        rst;
	logic        restart;
	logic        run;
	logic        halted;
	hostReqT     hostReq;
	logic [15:0] hostRdData;
	logic [31:0] seed = 32'hd5af;
	int          cycleCount = 0;
	entryT       vectors [tableLen];
	logic [15:0] prog [$];

	clockGen clocks (
		.restart(restart),
		.clk    (clk),
		.rst    (rst)
	);

	processorTop u_dut (
		.clk       (clk),
		.rst       (rst),
		.run       (run),
		.hostReq   (hostReq),
		.hostRdData(hostRdData),
		.halted    (halted)
	);

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	end

	function automatic logic [15:0] randWord();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed[31:16];
	endfunction

	// Expected ALU result and flags
	function automatic aluRefT aluRef(opcodeT op, logic [15:0] x, logic [15:0] y);
		aluRefT res;
		res = '0;
		case (op)
			ADD: begin
				res.r = x + y;
				// A wrapped sum is smaller than either addend
				res.c = (res.r < x);
			end
			SUB: begin
				res.r = x - y;
				res.c = (x < y);
			end
			AND: res.r = x & y;
			OR:  res.r = x | y;
			XOR: res.r = x ^ y;
			SHL: begin
				res.r = {x[14:0], 1'b0};
				res.c = x[15];
			end
			SHR: begin
				res.r = {1'b0, x[15:1]};
				res.c = x[0];
			end
			MOV: res.r = y;
			default: res.r = '0;
		endcase
		res.z = (res.r == 16'h0);
		return res;
	endfunction

	function automatic logic [15:0] enc(opcodeT op, logic [3:0] dst, logic [7:0] low);
		return {op, dst, low};
	endfunction

	task automatic check(string name, logic [15:0] got, logic [15:0] expected);
		if (got !== expected) begin
			$display("Fail %s: got 0x%h, expected 0x%h", name, got, expected);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	endtask

	task automatic hostWrite(logic [7:0] wordAddr, logic [15:0] wordData);
		@(posedge clk);
		hostReq <= '{we: 1'b1, addr: wordAddr, wrData: wordData};
	endtask

	task automatic readWord(logic [7:0] wordAddr, output logic [15:0] wordData);
		@(posedge clk);
		hostReq <= '{we: 1'b0, addr: wordAddr, wrData: 16'h0};
		@(negedge clk);
		wordData = hostRdData;
	endtask

	task automatic restartDut();
		@(posedge clk);
		restart <= 1'b1;
		@(posedge clk);
		restart <= 1'b0;
		@(negedge rst);
	endtask

	// Op under test, result and flag markers, LD/ST copy, poison skipped by JMP and JR
	task automatic buildProgram(entryT e);
		prog.delete();
		prog.push_back(enc(LDI, 4'd1, e.a));
		prog.push_back(enc(LDI, 4'd2, e.b));
		prog.push_back(enc(e.op, 4'd1, 8'h20));
		prog.push_back(enc(LDI, 4'd3, 8'hf0));
		prog.push_back(enc(ST, 4'd3, 8'h10));
		prog.push_back(enc(LDI, 4'd4, 8'd1));
		prog.push_back(enc(LDI, 4'd3, 8'hf1));
		prog.push_back(enc(JZ, 4'd0, 8'd9));
		prog.push_back(enc(LDI, 4'd4, 8'd2));
		prog.push_back(enc(ST, 4'd3, 8'h40));
		prog.push_back(enc(LDI, 4'd4, 8'd1));
		prog.push_back(enc(LDI, 4'd3, 8'hf2));
		prog.push_back(enc(JC, 4'd0, 8'd14));
		prog.push_back(enc(LDI, 4'd4, 8'd2));
		prog.push_back(enc(ST, 4'd3, 8'h40));
		prog.push_back(enc(LDI, 4'd5, 8'hf3));
		prog.push_back(enc(LD, 4'd6, 8'h50));
		prog.push_back(enc(LDI, 4'd7, 8'hf4));
		prog.push_back(enc(ST, 4'd7, 8'h60));
		prog.push_back(enc(LDI, 4'd8, 8'hde));
		prog.push_back(enc(LDI, 4'd9, 8'hf5));
		prog.push_back(enc(JMP, 4'd0, 8'd23));
		prog.push_back(enc(ST, 4'd9, 8'h80));
		prog.push_back(enc(LDI, 4'd10, 8'd26));
		prog.push_back(enc(JR, 4'd0, 8'ha0));
		prog.push_back(enc(ST, 4'd9, 8'h80));
		prog.push_back(enc(HLT, 4'd0, 8'h00));
	endtask

	task automatic runProgram(int expCycles);
		int cycles;
		cycles = 0;
		@(posedge clk);
		hostReq.we <= 1'b0;
		@(posedge clk);
		run <= 1'b1;
		// Count edges after the one that raised run
		while (!halted) begin
			@(posedge clk);
			cycles++;
			@(negedge clk);
		end
		check("halted cycles", 16'(cycles), 16'(expCycles));
		@(posedge clk);
		run <= 1'b0;
	endtask

	initial begin
		entryT       e;
		aluRefT      model;
		logic [15:0] word;
		logic [15:0] ldWord;
		logic [15:0] echo [8];
		run     = 1'b0;
		restart = 1'b0;
		hostReq = '0;

		// Corner rows
		vectors[0] = '{op: ADD, a: 8'h00, b: 8'h00, cTaken: 1'b0, zTaken: 1'b1};
		vectors[1] = '{op: ADD, a: 8'hff, b: 8'h01, cTaken: 1'b0, zTaken: 1'b0};
		word = randWord();
		vectors[2] = '{op: SUB, a: word[7:0], b: word[7:0], cTaken: 1'b0, zTaken: 1'b1};
		for (int k = 3; k < tableLen; k++) begin
			e.op = opcodeT'(4'((k - 3) % 8));
			word = randWord();
			e.a  = word[7:0];
			word = randWord();
			e.b  = word[7:0];
			model = aluRef(e.op, 16'(e.a), 16'(e.b));
			e.cTaken = model.c;
			e.zTaken = model.z;
			vectors[k] = e;
		end

		@(negedge rst);
		check("halted", 16'(halted), 16'h0);
		for (int k = 0; k < 8; k++) begin
			echo[k] = randWord();
			hostWrite(8'(8'h80 + k), echo[k]);
		end
		for (int k = 0; k < 8; k++) begin
			readWord(8'(8'h80 + k), word);
			check("hostRdData", word, echo[k]);
		end

		for (int i = 0; i < tableLen; i++) begin
			restartDut();
			check("halted", 16'(halted), 16'h0);
			e = vectors[i];
			ldWord = randWord();
			buildProgram(e);
			foreach (prog[j]) begin
				hostWrite(8'(j), prog[j]);
			end
			// Data words at F0..F5 with the LD source at F3
			for (int k = 0; k < 6; k++) begin
				hostWrite(8'(8'hf0 + k), (k == 3) ? ldWord : 16'h0);
			end
			runProgram(2 * (25 - int'(e.zTaken) - int'(e.cTaken)));
			model = aluRef(e.op, 16'(e.a), 16'(e.b));
			readWord(8'hf0, word);
			check("result", word, model.r);
			readWord(8'hf1, word);
			check("zero marker", word, e.zTaken ? 16'd1 : 16'd2);
			readWord(8'hf2, word);
			check("carry marker", word, e.cTaken ? 16'd1 : 16'd2);
			readWord(8'hf4, word);
			check("loaded word", word, ldWord);
			readWord(8'hf5, word);
			check("poison slot", word, 16'h0);
		end

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: tb.f
design/cpuPkg.sv
design/registerFile.sv
design/alu.sv
design/decoder.sv
design/processor.sv
design/processorTop.sv
tests/clockGen.sv
tests/tbTop.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tbTop -o simv

status=0
./obj_dir/simv > sim.log 2>&1 || status=$?
cat sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
	echo "Simulation reported failure"
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit "$status"
fi
echo "Simulation finished without failure"
